/* design/xbar_addr_decode.sv */
// Address decoder for the fixed two-target map
// Unmapped addresses select the error responder route
`timescale 1ns/1ps
`include "xbar_params.svh"

module xbar_addr_decode (
  input  logic [`XBAR_ADDR_W-1:0] addr_i,
  output xbar_pkg::xbar_sel_t     sel_o
);
  import xbar_pkg::*;

  logic [`XBAR_ADDR_W-1:0] off0;
  logic [`XBAR_ADDR_W-1:0] off1;

  // Offsets wrap, so one compare per range is enough
  assign off0 = addr_i - `XBAR_T0_BASE;
  assign off1 = addr_i - `XBAR_T1_BASE;

  always_comb begin
    if (off0 < `XBAR_TGT_SIZE) begin
      sel_o = xbar_sel_t'(0);
    end else if (off1 < `XBAR_TGT_SIZE) begin
      sel_o = xbar_sel_t'(1);
    end else begin
      sel_o = xbar_sel_t'(`XBAR_N_TGT);  // Decode error route
    end
  end

endmodule

/* design/xbar_decerr_resp.sv */
// Decode-error responder, one registered error response per request
`timescale 1ns/1ps
`include "xbar_params.svh"

module xbar_decerr_resp (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_valid_i,
  input  xbar_pkg::xbar_req_t req_i,
  output logic                rsp_valid_o,
  output xbar_pkg::xbar_rsp_t rsp_o
);
  import xbar_pkg::*;

  logic      rsp_valid_q;
  xbar_rsp_t rsp_d;
  xbar_rsp_t rsp_q;

  always_comb begin
    rsp_d                  = '0;
    rsp_d.err              = 1'b1;
    rsp_d.payload.err.code = XBAR_ERR_DECODE;
    rsp_d.payload.err.addr = req_i.addr;  // Report where it failed
    rsp_d.id               = req_i.id;
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q <= rsp_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

/* design/xbar_demux.sv */
// Per-initiator request FIFO with credit return to the initiator
// Routes the FIFO head to a target mux or the error responder
// Locks the route while requests are outstanding and picks responses
`timescale 1ns/1ps
`include "xbar_params.svh"

module xbar_demux (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      req_valid_i,
  input  xbar_pkg::xbar_req_t                       req_i,
  output logic                                      req_credit_o,
  output logic                                      rsp_valid_o,
  output xbar_pkg::xbar_rsp_t                       rsp_o,
  output logic [`XBAR_N_TGT-1:0]                    fwd_valid_o,
  output xbar_pkg::xbar_req_t                       fwd_req_o,
  input  logic [`XBAR_N_TGT-1:0]                    fwd_grant_i,
  output logic                                      err_valid_o,
  input  logic [`XBAR_N_TGT:0]                      ret_valid_i,
  input  xbar_pkg::xbar_rsp_t [`XBAR_N_TGT:0]       ret_rsp_i
);
  import xbar_pkg::*;

  localparam int ptr_w = $clog2(`XBAR_REQ_DEPTH);
  localparam int cnt_w = $clog2(`XBAR_REQ_DEPTH + 1);
  localparam int outst_w = $clog2(`XBAR_MAX_OUTST + 1);

  xbar_req_t [`XBAR_REQ_DEPTH-1:0] fifo_mem;
  logic [ptr_w-1:0]                wr_ptr_q;
  logic [ptr_w-1:0]                rd_ptr_q;
  logic [cnt_w-1:0]                count_q;
  logic [outst_w-1:0]              outst_q;
  xbar_sel_t                       lock_sel_q;
  logic                            credit_q;
  xbar_sel_t                       head_sel;
  logic                            can_issue;
  logic                            pop;

  assign fwd_req_o = fifo_mem[rd_ptr_q];

  xbar_addr_decode u_decode (
    .addr_i (fwd_req_o.addr),
    .sel_o  (head_sel)
  );

  // Only follow the locked route while anything is in flight
  assign can_issue = (count_q != '0) && (outst_q != outst_w'(`XBAR_MAX_OUTST)) &&
                     ((outst_q == '0) || (head_sel == lock_sel_q));

  always_comb begin
    fwd_valid_o = '0;
    err_valid_o = 1'b0;
    pop         = 1'b0;
    if (head_sel == xbar_sel_t'(`XBAR_N_TGT)) begin
      err_valid_o = can_issue;
      pop         = can_issue;  // Error responder never stalls
    end else begin
      fwd_valid_o[head_sel[0]] = can_issue;
      pop = can_issue && fwd_grant_i[head_sel[0]];
    end
  end

  // Responses only come from the locked source
  assign rsp_valid_o  = ret_valid_i[lock_sel_q];
  assign rsp_o        = ret_rsp_i[lock_sel_q];
  assign req_credit_o = credit_q;

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      fifo_mem[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      outst_q    <= '0;
      lock_sel_q <= '0;
      credit_q   <= 1'b0;
    end else begin
      credit_q <= pop;  // One credit back per pop
      if (req_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(`XBAR_REQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q   <= (rd_ptr_q == ptr_w'(`XBAR_REQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        lock_sel_q <= head_sel;
      end
      if (req_valid_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!req_valid_i && pop) begin
        count_q <= count_q - 1'b1;
      end
      if (pop && !rsp_valid_o) begin
        outst_q <= outst_q + 1'b1;
      end else if (!pop && rsp_valid_o) begin
        outst_q <= outst_q - 1'b1;
      end
    end
  end

endmodule

/* design/xbar_mux.sv */
// Per-target round-robin arbiter and target credit counter
// Adds the initiator index as top ID bit and routes responses back
`timescale 1ns/1ps
`include "xbar_params.svh"

module xbar_mux (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic [`XBAR_N_INIT-1:0]                req_valid_i,
  input  xbar_pkg::xbar_req_t [`XBAR_N_INIT-1:0] req_i,
  output logic [`XBAR_N_INIT-1:0]                grant_o,
  output logic [`XBAR_N_INIT-1:0]                rsp_valid_o,
  output xbar_pkg::xbar_rsp_t                    rsp_o,
  output logic                                   tgt_req_valid_o,
  output xbar_pkg::xbar_tgt_req_t                tgt_req_o,
  input  logic                                   tgt_req_credit_i,
  input  logic                                   tgt_rsp_valid_i,
  input  xbar_pkg::xbar_tgt_rsp_t                tgt_rsp_i
);
  import xbar_pkg::*;

  localparam int idx_w = `XBAR_TGT_ID_W - `XBAR_ID_W;
  localparam int crd_w = $clog2(`XBAR_TGT_CREDITS + 1);

  logic [idx_w-1:0] prio_q;    // Initiator with highest priority
  logic [idx_w-1:0] cand;
  logic [idx_w-1:0] gnt_idx;
  logic             gnt_any;
  logic [crd_w-1:0] credit_q;
  logic             valid_q;
  xbar_tgt_req_t    tgt_req_q;
  logic [idx_w-1:0] rsp_src;

  always_comb begin
    grant_o = '0;
    gnt_any = 1'b0;
    gnt_idx = prio_q;
    cand    = prio_q;
    // Walk from the priority pointer, first valid request wins
    for (int k = 0; k < `XBAR_N_INIT; k++) begin
      cand = idx_w'((int'(prio_q) + k) % `XBAR_N_INIT);
      if (!gnt_any && req_valid_i[cand] && (credit_q != '0)) begin
        gnt_any = 1'b1;
        gnt_idx = cand;
      end
    end
    if (gnt_any) begin
      grant_o[gnt_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_any) begin
      tgt_req_q.we    <= req_i[gnt_idx].we;
      tgt_req_q.addr  <= req_i[gnt_idx].addr;
      tgt_req_q.wdata <= req_i[gnt_idx].wdata;
      tgt_req_q.id    <= {gnt_idx, req_i[gnt_idx].id};  // Widened ID
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q   <= '0;
      valid_q  <= 1'b0;
      credit_q <= crd_w'(`XBAR_TGT_CREDITS);
    end else begin
      valid_q <= gnt_any;
      if (gnt_any) begin
        prio_q <= idx_w'((int'(gnt_idx) + 1) % `XBAR_N_INIT);
      end
      if (gnt_any && !tgt_req_credit_i) begin
        credit_q <= credit_q - 1'b1;
      end else if (!gnt_any && tgt_req_credit_i) begin
        credit_q <= credit_q + 1'b1;
      end
    end
  end

  assign tgt_req_valid_o = valid_q;
  assign tgt_req_o       = tgt_req_q;

  // Response goes back to the initiator named by the top ID bit
  assign rsp_src = tgt_rsp_i.id[`XBAR_TGT_ID_W-1 -: idx_w];

  always_comb begin
    rsp_valid_o = '0;
    rsp_valid_o[rsp_src] = tgt_rsp_valid_i;
  end

  assign rsp_o.err     = tgt_rsp_i.err;
  assign rsp_o.payload = tgt_rsp_i.payload;
  assign rsp_o.id      = tgt_rsp_i.id[`XBAR_ID_W-1:0];  // Strip the index

endmodule

/* design/xbar_pkg.sv */
// Request and response structs for both sides of the crossbar
// Payload union with read data and error views, route index type
`include "xbar_params.svh"

package xbar_pkg;

  // Initiator-side request, single beat read or write
  typedef struct packed {
    logic                    we;
    logic [`XBAR_ADDR_W-1:0] addr;
    logic [`XBAR_DATA_W-1:0] wdata;
    logic [`XBAR_ID_W-1:0]   id;
  } xbar_req_t;

  // Target-side request with the widened ID
  typedef struct packed {
    logic                      we;
    logic [`XBAR_ADDR_W-1:0]   addr;
    logic [`XBAR_DATA_W-1:0]   wdata;
    logic [`XBAR_TGT_ID_W-1:0] id;
  } xbar_tgt_req_t;

  // Response word, decoded by the error flag
  typedef union packed {
    logic [`XBAR_DATA_W-1:0] rdata;
    struct packed {
      logic [7:0]              pad;   // Always zero
      logic [7:0]              code;
      logic [`XBAR_ADDR_W-1:0] addr;  // Failing address
    } err;
  } xbar_payload_u;

  typedef struct packed {
    logic                  err;
    xbar_payload_u         payload;
    logic [`XBAR_ID_W-1:0] id;
  } xbar_rsp_t;

  typedef struct packed {
    logic                      err;
    xbar_payload_u             payload;
    logic [`XBAR_TGT_ID_W-1:0] id;
  } xbar_tgt_rsp_t;

  // Targets are 0 and 1, the error responder is 2
  typedef logic [1:0] xbar_sel_t;

  localparam logic [7:0] XBAR_ERR_DECODE = 8'hDE;

endpackage

/* design/xbar_top.sv */
// Two-by-two crossbar top level
// Demuxes and error responders per initiator, muxes per target, crossing wires
`timescale 1ns/1ps
`include "xbar_params.svh"

module xbar_top (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic [`XBAR_N_INIT-1:0]                   init_req_valid_i,
  input  xbar_pkg::xbar_req_t [`XBAR_N_INIT-1:0]    init_req_i,
  output logic [`XBAR_N_INIT-1:0]                   init_req_credit_o,
  output logic [`XBAR_N_INIT-1:0]                   init_rsp_valid_o,
  output xbar_pkg::xbar_rsp_t [`XBAR_N_INIT-1:0]    init_rsp_o,
  output logic [`XBAR_N_TGT-1:0]                    tgt_req_valid_o,
  output xbar_pkg::xbar_tgt_req_t [`XBAR_N_TGT-1:0] tgt_req_o,
  input  logic [`XBAR_N_TGT-1:0]                    tgt_req_credit_i,
  input  logic [`XBAR_N_TGT-1:0]                    tgt_rsp_valid_i,
  input  xbar_pkg::xbar_tgt_rsp_t [`XBAR_N_TGT-1:0] tgt_rsp_i
);
  import xbar_pkg::*;

  // Demux side, indexed [initiator][route]
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0]    dmx_fwd_valid;
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0]    dmx_grant;
  xbar_req_t [`XBAR_N_INIT-1:0]                dmx_fwd_req;
  logic [`XBAR_N_INIT-1:0]                     dmx_err_valid;
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TGT:0]      dmx_ret_valid;
  xbar_rsp_t [`XBAR_N_INIT-1:0][`XBAR_N_TGT:0] dmx_ret_rsp;

  // Mux side, indexed [target][initiator]
  logic [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0]    mux_req_valid;
  logic [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0]    mux_grant;
  logic [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0]    mux_rsp_valid;
  xbar_rsp_t [`XBAR_N_TGT-1:0]                 mux_rsp;

  for (genvar i = 0; i < `XBAR_N_INIT; i++) begin : gen_init
    xbar_demux u_demux (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_valid_i  (init_req_valid_i[i]),
      .req_i        (init_req_i[i]),
      .req_credit_o (init_req_credit_o[i]),
      .rsp_valid_o  (init_rsp_valid_o[i]),
      .rsp_o        (init_rsp_o[i]),
      .fwd_valid_o  (dmx_fwd_valid[i]),
      .fwd_req_o    (dmx_fwd_req[i]),
      .fwd_grant_i  (dmx_grant[i]),
      .err_valid_o  (dmx_err_valid[i]),
      .ret_valid_i  (dmx_ret_valid[i]),
      .ret_rsp_i    (dmx_ret_rsp[i])
    );

    xbar_decerr_resp u_decerr (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_valid_i (dmx_err_valid[i]),
      .req_i       (dmx_fwd_req[i]),
      .rsp_valid_o (dmx_ret_valid[i][`XBAR_N_TGT]),  // Last route is the error path
      .rsp_o       (dmx_ret_rsp[i][`XBAR_N_TGT])
    );

    for (genvar t = 0; t < `XBAR_N_TGT; t++) begin : gen_cross
      assign mux_req_valid[t][i] = dmx_fwd_valid[i][t];
      assign dmx_grant[i][t]     = mux_grant[t][i];
      assign dmx_ret_valid[i][t] = mux_rsp_valid[t][i];
      assign dmx_ret_rsp[i][t]   = mux_rsp[t];
    end
  end

  for (genvar t = 0; t < `XBAR_N_TGT; t++) begin : gen_tgt
    xbar_mux u_mux (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .req_valid_i      (mux_req_valid[t]),
      .req_i            (dmx_fwd_req),
      .grant_o          (mux_grant[t]),
      .rsp_valid_o      (mux_rsp_valid[t]),
      .rsp_o            (mux_rsp[t]),
      .tgt_req_valid_o  (tgt_req_valid_o[t]),
      .tgt_req_o        (tgt_req_o[t]),
      .tgt_req_credit_i (tgt_req_credit_i[t]),
      .tgt_rsp_valid_i  (tgt_rsp_valid_i[t]),
      .tgt_rsp_i        (tgt_rsp_i[t])
    );
  end

endmodule

/* include/xbar_params.svh */
// Crossbar sizes, field widths and credit depths
// Fixed address map of the two targets
`ifndef XBAR_PARAMS_SVH
`define XBAR_PARAMS_SVH

`define XBAR_N_INIT 2
`define XBAR_N_TGT 2

`define XBAR_ADDR_W 16
`define XBAR_DATA_W 32
`define XBAR_ID_W 2
`define XBAR_TGT_ID_W (`XBAR_ID_W + 1)  // Top bit carries the initiator index

`define XBAR_REQ_DEPTH 2    // Also the initiator's starting credit
`define XBAR_TGT_CREDITS 2
`define XBAR_MAX_OUTST 3

// Target 0 and target 1, everything else is a decode error
`define XBAR_T0_BASE 16'h0000
`define XBAR_T1_BASE 16'h1000
`define XBAR_TGT_SIZE 16'h1000

`endif

/* run_sim.sh */
#!/bin/sh
# Build the crossbar testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f xbar.f --top-module xbar_tb -o xbar_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/xbar_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

/* verification/xbar_tb.sv */
// Testbench for the two-by-two crossbar
// Initiator drivers with credit tracking, target memory models
// Reference function for expected responses and the response checker
`timescale 1ns/1ps
`include "xbar_params.svh"

module xbar_tb;
  import xbar_pkg::*;

  localparam int n_hold = 60;  // Cycles with target credits withheld

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic [`XBAR_N_INIT-1:0]          init_req_valid;
  xbar_req_t [`XBAR_N_INIT-1:0]     init_req;
  logic [`XBAR_N_INIT-1:0]          init_req_credit;
  logic [`XBAR_N_INIT-1:0]          init_rsp_valid;
  xbar_rsp_t [`XBAR_N_INIT-1:0]     init_rsp;
  logic [`XBAR_N_TGT-1:0]           tgt_req_valid;
  xbar_tgt_req_t [`XBAR_N_TGT-1:0]  tgt_req;
  logic [`XBAR_N_TGT-1:0]           tgt_req_credit;
  logic [`XBAR_N_TGT-1:0]           tgt_rsp_valid;
  xbar_tgt_rsp_t [`XBAR_N_TGT-1:0]  tgt_rsp;

  xbar_req_t             stim_q [`XBAR_N_INIT][$];  // Requests waiting to be issued
  xbar_rsp_t             exp_q [`XBAR_N_INIT][$];   // Expected responses in issue order
  logic [31:0]           shadow [`XBAR_N_INIT][0:2047];
  int                    credits [`XBAR_N_INIT];
  int                    outst [`XBAR_N_INIT];
  logic [`XBAR_ID_W-1:0] next_id [`XBAR_N_INIT];
  xbar_tgt_req_t         tq [`XBAR_N_TGT][$];
  int                    tdelay [`XBAR_N_TGT];
  int                    tcred [`XBAR_N_TGT];       // Credits the crossbar may still use
  logic [31:0]           tmem [`XBAR_N_TGT][0:1023];
  logic                  hold;
  logic                  hold_check;
  logic [31:0]           stim_seed;
  logic [31:0]           tgt_seed;
  int                    mismatches;
  int                    failures;
  int                    n_req;
  int                    n_rsp;
  int                    cycles;

  xbar_top UUT (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .init_req_valid_i  (init_req_valid),
    .init_req_i        (init_req),
    .init_req_credit_o (init_req_credit),
    .init_rsp_valid_o  (init_rsp_valid),
    .init_rsp_o        (init_rsp),
    .tgt_req_valid_o   (tgt_req_valid),
    .tgt_req_o         (tgt_req),
    .tgt_req_credit_i  (tgt_req_credit),
    .tgt_rsp_valid_i   (tgt_rsp_valid),
    .tgt_rsp_i         (tgt_rsp)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Target in bit 12 and initiator in bit 8 above the word offset
  function automatic logic [15:0] word_addr(input int tgt, input int src, input int word);
    return 16'(tgt << 12) | 16'(src << 8) | 16'(word << 2);
  endfunction

  // Mapped space is two targets of 0x1000 each up to 0x2000
  function automatic xbar_rsp_t xbar_expect(input int src, input xbar_req_t req,
                                            input logic [31:0] mem [`XBAR_N_INIT][0:2047]);
    xbar_rsp_t rsp;
    rsp    = '0;
    rsp.id = req.id;
    if (req.addr >= 16'h2000) begin
      rsp.err              = 1'b1;
      rsp.payload.err.code = 8'hDE;
      rsp.payload.err.addr = req.addr;
    end else if (!req.we) begin
      rsp.payload.rdata = mem[src][req.addr[12:2]];  // Zero if never written
    end
    return rsp;
  endfunction

  task automatic push_req(input int src, input logic we, input logic [15:0] addr,
                          input logic [31:0] data);
    xbar_req_t r;
    r.we          = we;
    r.addr        = addr;
    r.wdata       = data;
    r.id          = next_id[src];
    next_id[src]  = next_id[src] + 1'b1;
    stim_q[src].push_back(r);
    n_req++;
  endtask

  task automatic wait_idle();
    while (stim_q[0].size() + stim_q[1].size() + exp_q[0].size() + exp_q[1].size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);  // Let the last credits settle
  endtask

  // Initiator drivers
  always @(negedge clk) begin
    xbar_req_t r;
    for (int i = 0; i < `XBAR_N_INIT; i++) begin
      if (init_req_credit[i]) credits[i]++;
      if (init_rsp_valid[i]) outst[i]--;
      if (rst_n && stim_q[i].size() != 0 && credits[i] > 0 && outst[i] < `XBAR_MAX_OUTST) begin
        r = stim_q[i].pop_front();
        init_req_valid[i] <= 1'b1;
        init_req[i]       <= r;
        credits[i]--;
        outst[i]++;
        exp_q[i].push_back(xbar_expect(i, r, shadow));
        if (r.we && r.addr < 16'h2000) shadow[i][r.addr[12:2]] = r.wdata;
      end else begin
        init_req_valid[i] <= 1'b0;
      end
    end
  end

  // Target memory models answer in arrival order
  always @(negedge clk) begin
    xbar_tgt_req_t h;
    xbar_tgt_rsp_t rsp;
    for (int t = 0; t < `XBAR_N_TGT; t++) begin
      tgt_rsp_valid[t]  <= 1'b0;
      tgt_req_credit[t] <= 1'b0;
      if (rst_n && !hold && tq[t].size() != 0) begin
        if (tdelay[t] > 1) begin
          tdelay[t]--;
        end else begin
          h      = tq[t].pop_front();
          rsp    = '0;
          rsp.id = h.id;  // Echo the widened ID
          if (h.we) begin
            tmem[t][h.addr[11:2]] = h.wdata;
          end else begin
            rsp.payload.rdata = tmem[t][h.addr[11:2]];
          end
          tgt_rsp[t]        <= rsp;
          tgt_rsp_valid[t]  <= 1'b1;
          tgt_req_credit[t] <= 1'b1;
          tcred[t]++;
          tgt_seed  = lcg(tgt_seed);
          tdelay[t] = 1 + int'(tgt_seed[31:16] % 16'd3);
        end
      end
      if (rst_n && tgt_req_valid[t]) begin
        h = tgt_req[t];
        assert (tcred[t] > 0) else begin
          failures++;
          $display("Target %0d received a request at %0t without a credit", t, $time);
        end
        assert (h.addr[15:12] == 4'(t)) else begin
          failures++;
          $display("Request for address %h reached target %0d at %0t", h.addr, t, $time);
        end
        assert (h.id[`XBAR_TGT_ID_W-1] == h.addr[8]) else begin
          mismatches++;
          $display("Mismatch at %0t: tgt_req_o[%0d].id[2] got %0b expected %0b",
                   $time, t, h.id[`XBAR_TGT_ID_W-1], h.addr[8]);
        end
        tcred[t]--;
        tq[t].push_back(h);
      end
    end
  end

  // Response checker
  always @(negedge clk) begin
    xbar_rsp_t exp_rsp;
    for (int i = 0; i < `XBAR_N_INIT; i++) begin
      if (rst_n && init_rsp_valid[i]) begin
        n_rsp++;
        assert (exp_q[i].size() != 0) else begin
          failures++;
          $display("Initiator %0d got a response at %0t with nothing outstanding", i, $time);
        end
        if (exp_q[i].size() != 0) begin
          exp_rsp = exp_q[i].pop_front();
          assert (init_rsp[i] === exp_rsp) else begin
            mismatches++;
            $display("Mismatch at %0t: init_rsp_o[%0d] got %h expected %h",
                     $time, i, init_rsp[i], exp_rsp);
          end
        end
      end
    end
    if (hold_check) begin
      assert (init_req_credit == '0) else begin
        failures++;
        $display("Initiator credit returned at %0t while targets hold their credits", $time);
      end
    end
  end

  always @(negedge clk) begin
    cycles++;
    if (cycles > 20 * n_req + 200) begin
      failures++;
      $display("Timeout after %0d cycles, %0d responses missing", cycles, n_req - n_rsp);
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    logic [15:0] addr;
    logic [31:0] data;
    int          src;
    rst_n          = 1'b0;
    init_req_valid = '0;
    init_req       = '0;
    tgt_req_credit = '0;
    tgt_rsp_valid  = '0;
    tgt_rsp        = '0;
    hold           = 1'b0;
    hold_check     = 1'b0;
    stim_seed      = 32'hc9264f28;
    tgt_seed       = lcg(32'hc9264f28);
    mismatches     = 0;
    failures       = 0;
    n_req          = 0;
    n_rsp          = 0;
    cycles         = 0;
    for (int i = 0; i < `XBAR_N_INIT; i++) begin
      credits[i] = `XBAR_REQ_DEPTH;
      outst[i]   = 0;
      next_id[i] = '0;
      for (int w = 0; w < 2048; w++) shadow[i][w] = '0;
    end
    for (int t = 0; t < `XBAR_N_TGT; t++) begin
      tdelay[t] = 1;
      tcred[t]  = `XBAR_TGT_CREDITS;
      for (int w = 0; w < 1024; w++) tmem[t][w] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Writes then reads from initiator 0 to both targets
    for (int k = 0; k < 8; k++) begin
      stim_seed = lcg(stim_seed);
      push_req(0, 1'b1, word_addr(k / 4, 0, k % 4), stim_seed);
    end
    for (int k = 0; k < 8; k++) push_req(0, 1'b0, word_addr(k / 4, 0, k % 4), '0);
    wait_idle();

    // Unmapped accesses mixed with mapped reads
    push_req(1, 1'b0, 16'h2000, '0);
    push_req(1, 1'b1, 16'hF000, 32'h1234_5678);
    push_req(1, 1'b0, word_addr(0, 1, 5), '0);
    push_req(1, 1'b0, 16'h8ABC, '0);
    push_req(1, 1'b0, word_addr(1, 1, 7), '0);
    push_req(1, 1'b1, 16'hFFFC, 32'hCAFE_F00D);
    wait_idle();

    // Both initiators on target 1
    for (int k = 0; k < 16; k++) begin
      stim_seed = lcg(stim_seed);
      push_req(k % 2, k < 8, word_addr(1, k % 2, (k / 2) % 4), stim_seed);
    end
    wait_idle();

    // Targets stop returning credits
    hold <= 1'b1;
    for (int k = 0; k < 12; k++) begin
      stim_seed = lcg(stim_seed);
      push_req(k % 2, stim_seed[0], word_addr(0, k % 2, k), stim_seed);
    end
    repeat (n_hold / 2) @(posedge clk);
    hold_check <= 1'b1;
    repeat (n_hold / 2) @(posedge clk);
    hold_check <= 1'b0;
    hold       <= 1'b0;
    wait_idle();

    // Random mix over both targets and unmapped space
    for (int k = 0; k < 200; k++) begin
      stim_seed = lcg(stim_seed);
      src       = int'(stim_seed[31]);
      if (stim_seed[30:29] == 2'b00) begin
        addr = {stim_seed[20:18], stim_seed[12:0]} | 16'h2000;
      end else begin
        addr = word_addr(int'(stim_seed[28]), src, int'(stim_seed[27:22]));
      end
      data = lcg(stim_seed ^ 32'h5a5a_5a5a);
      push_req(src, stim_seed[21], addr, data);
    end
    wait_idle();

    assert (n_rsp == n_req) else begin
      failures++;
      $display("Response count %0d differs from request count %0d", n_rsp, n_req);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* xbar.f */
+incdir+include
design/xbar_pkg.sv
design/xbar_addr_decode.sv
design/xbar_demux.sv
design/xbar_mux.sv
design/xbar_decerr_resp.sv
design/xbar_top.sv
verification/xbar_tb.sv
